// ==== filelist.f ====
+incdir+test
hw/soc_bus_pkg.sv
hw/soc_map_pkg.sv
hw/bus_ctrl_fsm.sv
hw/timer_counter.sv
hw/gpio_regs.sv
hw/demo_soc_top.sv
test/tb_demo_soc.sv

// ==== hw/bus_ctrl_fsm.sv ====
// Single-host bus controller. Decodes each request, forwards it to RAM, GPIO or timer
// and returns exactly one response per accepted request.
`timescale 1ns/1ps

module bus_ctrl_fsm (
  input  logic                   clk_sys_i,
  input  logic                   rst_sys_ni,
  input  soc_bus_pkg::bus_req_t  host_req_i,
  output logic                   host_gnt_o,
  output soc_bus_pkg::bus_rsp_t  host_rsp_o,
  output soc_bus_pkg::bus_req_t  mem_req_o,
  input  logic                   mem_rvalid_i,
  input  soc_bus_pkg::bus_word_t mem_rdata_i,
  output soc_bus_pkg::bus_req_t  gpio_req_o,
  input  soc_bus_pkg::bus_word_t gpio_rdata_i,
  output soc_bus_pkg::bus_req_t  timer_req_o,
  input  soc_bus_pkg::bus_word_t timer_rdata_i
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  typedef enum logic {
    Idle,
    WaitRam
  } state_e;

  state_e    state_q;
  soc_dev_e  dev_sel;
  logic      accept;
  logic      rvalid_q;
  logic      err_q;
  bus_word_t rdata_q;
  logic      ram_we_q;  // RAM writes answer with zero data

  // RAM from the raw word, peripherals from the page number
  always_comb begin
    dev_sel = DevNone;
    if ((host_req_i.addr.raw & RamMask) == RamStart) begin
      dev_sel = DevRam;
    end else if (host_req_i.addr.fld.region == GpioRegion) begin
      dev_sel = DevGpio;
    end else if (host_req_i.addr.fld.region == TimerRegion) begin
      dev_sel = DevTimer;
    end
  end

  assign host_gnt_o = host_req_i.req && (state_q == Idle);
  assign accept     = host_gnt_o;

  // Fields pass through, only the selected target sees req
  always_comb begin
    mem_req_o       = host_req_i;
    gpio_req_o      = host_req_i;
    timer_req_o     = host_req_i;
    mem_req_o.req   = accept && (dev_sel == DevRam);
    gpio_req_o.req  = accept && (dev_sel == DevGpio);
    timer_req_o.req = accept && (dev_sel == DevTimer);
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      state_q  <= Idle;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= 1'b0;
      if (state_q == Idle) begin
        if (accept && (dev_sel == DevRam)) begin
          state_q <= WaitRam;
        end else if (accept) begin
          rvalid_q <= 1'b1;  // Fixed one-cycle answer
        end
      end else if (mem_rvalid_i) begin
        state_q  <= Idle;
        rvalid_q <= 1'b1;
      end
    end
  end

  // Response payload
  always_ff @(posedge clk_sys_i) begin
    if (accept) begin
      err_q    <= (dev_sel == DevNone);
      ram_we_q <= host_req_i.we;
      case (dev_sel)
        DevGpio:  rdata_q <= host_req_i.we ? '0 : gpio_rdata_i;
        DevTimer: rdata_q <= host_req_i.we ? '0 : timer_rdata_i;
        default:  rdata_q <= '0;
      endcase
    end else if ((state_q == WaitRam) && mem_rvalid_i) begin
      rdata_q <= ram_we_q ? '0 : mem_rdata_i;
    end
  end

  assign host_rsp_o = '{rvalid: rvalid_q, err: err_q, rdata: rdata_q};

endmodule

// ==== hw/demo_soc_top.sv ====
// Demo bus fabric top. One host port, an external RAM port, GPIO and a machine timer.
// Instances and wiring only.
`timescale 1ns/1ps

module demo_soc_top #(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16
) (
  input  logic                   clk_sys_i,
  input  logic                   rst_sys_ni,
  input  soc_bus_pkg::bus_req_t  bus_req_i,
  output logic                   bus_gnt_o,
  output soc_bus_pkg::bus_rsp_t  bus_rsp_o,
  output soc_bus_pkg::bus_req_t  mem_req_o,
  input  logic                   mem_rvalid_i,
  input  soc_bus_pkg::bus_word_t mem_rdata_i,
  input  logic [GpiWidth-1:0]    gp_i,
  output logic [GpoWidth-1:0]    gp_o,
  output logic                   timer_irq_o
);
  import soc_bus_pkg::*;

  bus_req_t  gpio_req;
  bus_req_t  timer_req;
  bus_word_t gpio_rdata;
  bus_word_t timer_rdata;

  bus_ctrl_fsm u_bus_ctrl_fsm (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .host_req_i    (bus_req_i),
    .host_gnt_o    (bus_gnt_o),
    .host_rsp_o    (bus_rsp_o),
    .mem_req_o     (mem_req_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .gpio_req_o    (gpio_req),
    .gpio_rdata_i  (gpio_rdata),
    .timer_req_o   (timer_req),
    .timer_rdata_i (timer_rdata)
  );

  gpio_regs #(
    .GpiWidth (GpiWidth),
    .GpoWidth (GpoWidth)
  ) u_gpio_regs (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .dev_req_i  (gpio_req),
    .rdata_o    (gpio_rdata),
    .gp_i       (gp_i),
    .gp_o       (gp_o)
  );

  timer_counter u_timer_counter (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .dev_req_i   (timer_req),
    .rdata_o     (timer_rdata),
    .timer_irq_o (timer_irq_o)
  );

endmodule

// ==== hw/gpio_regs.sv ====
// GPIO block with a byte-writable output register and synchronized inputs.
`timescale 1ns/1ps

module gpio_regs #(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16
) (
  input  logic                   clk_sys_i,
  input  logic                   rst_sys_ni,
  input  soc_bus_pkg::bus_req_t  dev_req_i,
  output soc_bus_pkg::bus_word_t rdata_o,
  input  logic [GpiWidth-1:0]    gp_i,
  output logic [GpoWidth-1:0]    gp_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic [GpiWidth-1:0] gpi_meta_q;
  logic [GpiWidth-1:0] gpi_sync_q;
  logic                out_wr;
  bus_word_t           out_merged;

  assign out_wr = dev_req_i.req && dev_req_i.we &&
                  (dev_req_i.addr.fld.offset == GpioOutOffset);

  // Merge on the full word, upper bytes fall away on truncation
  assign out_merged = bus_merge_be(BusDataWidth'(gp_o), dev_req_i.wdata, dev_req_i.be);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gp_o       <= '0;
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
      if (out_wr) begin
        gp_o <= out_merged[GpoWidth-1:0];
      end
    end
  end

  always_comb begin
    case (dev_req_i.addr.fld.offset)
      GpioOutOffset: rdata_o = BusDataWidth'(gp_o);
      GpioInOffset:  rdata_o = BusDataWidth'(gpi_sync_q);
      default:       rdata_o = '0;
    endcase
  end

endmodule

// ==== hw/soc_bus_pkg.sv ====
// Bus-level types for the demo fabric, shared by the RTL and the testbench.
// Import wherever a request, a response or a data word is carried.
package soc_bus_pkg;

  parameter int BusDataWidth = 32;
  parameter int BusAddrWidth = 32;

  typedef logic [BusDataWidth-1:0] bus_word_t;
  typedef logic [3:0]              bus_be_t;

  // Peripheral view, 4 KiB pages
  typedef struct packed {
    logic [BusAddrWidth-13:0] region;
    logic [11:0]              offset;
  } bus_addr_fields_t;

  typedef union packed {
    logic [BusAddrWidth-1:0] raw;  // RAM compare and RAM port
    bus_addr_fields_t        fld;  // Peripheral decode
  } bus_addr_u;

  typedef struct packed {
    logic      req;
    logic      we;
    bus_be_t   be;
    bus_addr_u addr;
    bus_word_t wdata;
  } bus_req_t;

  typedef struct packed {
    logic      rvalid;
    logic      err;
    bus_word_t rdata;
  } bus_rsp_t;

  // Replace the enabled bytes of a register word
  function automatic bus_word_t bus_merge_be(bus_word_t old_w, bus_word_t new_w, bus_be_t be);
    bus_word_t res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

// ==== hw/soc_map_pkg.sv ====
// Memory map of the demo fabric and the register offsets of each device.
// The address decoder and the peripherals import it; the testbench predicts routing with it.
package soc_map_pkg;

  // External RAM window, 64 KiB
  parameter logic [31:0] RamStart = 32'h0010_0000;
  parameter logic [31:0] RamMask  = 32'hFFFF_0000;

  // Peripheral pages
  parameter logic [19:0] GpioRegion  = 20'h80000;  // 0x80000000
  parameter logic [19:0] TimerRegion = 20'h80002;  // 0x80002000

  // GPIO registers
  parameter logic [11:0] GpioOutOffset = 12'h000;
  parameter logic [11:0] GpioInOffset  = 12'h004;

  // Machine timer registers, one 32-bit half each
  parameter logic [11:0] MtimeLoOffset    = 12'h000;
  parameter logic [11:0] MtimeHiOffset    = 12'h004;
  parameter logic [11:0] MtimecmpLoOffset = 12'h008;
  parameter logic [11:0] MtimecmpHiOffset = 12'h00C;

  typedef enum logic [1:0] {
    DevRam,
    DevGpio,
    DevTimer,
    DevNone
  } soc_dev_e;

endpackage

// ==== hw/timer_counter.sv ====
// Machine timer with a free-running 64-bit mtime and a 64-bit mtimecmp.
// Both are written per 32-bit half; the interrupt is a registered level.
`timescale 1ns/1ps

module timer_counter (
  input  logic                   clk_sys_i,
  input  logic                   rst_sys_ni,
  input  soc_bus_pkg::bus_req_t  dev_req_i,
  output soc_bus_pkg::bus_word_t rdata_o,
  output logic                   timer_irq_o
);
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic [63:0] mtime_d;
  logic [63:0] mtimecmp_d;
  logic [11:0] offset;
  logic        wr_en;
  logic        irq_q;

  assign offset = dev_req_i.addr.fld.offset;
  assign wr_en  = dev_req_i.req && dev_req_i.we;

  always_comb begin
    mtime_d    = mtime_q + 64'd1;
    mtimecmp_d = mtimecmp_q;
    if (wr_en) begin
      case (offset)
        MtimeLoOffset: begin
          mtime_d[31:0] = bus_merge_be(mtime_q[31:0], dev_req_i.wdata, dev_req_i.be);
        end
        MtimeHiOffset: begin
          mtime_d[63:32] = bus_merge_be(mtime_q[63:32], dev_req_i.wdata, dev_req_i.be);
        end
        MtimecmpLoOffset: begin
          mtimecmp_d[31:0] = bus_merge_be(mtimecmp_q[31:0], dev_req_i.wdata, dev_req_i.be);
        end
        MtimecmpHiOffset: begin
          mtimecmp_d[63:32] = bus_merge_be(mtimecmp_q[63:32], dev_req_i.wdata, dev_req_i.be);
        end
        default: ;  // Unknown offset, write dropped
      endcase
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;  // No interrupt until software sets a deadline
      irq_q      <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      irq_q      <= (mtime_q >= mtimecmp_q);
    end
  end

  always_comb begin
    case (offset)
      MtimeLoOffset:    rdata_o = mtime_q[31:0];
      MtimeHiOffset:    rdata_o = mtime_q[63:32];
      MtimecmpLoOffset: rdata_o = mtimecmp_q[31:0];
      MtimecmpHiOffset: rdata_o = mtimecmp_q[63:32];
      default:          rdata_o = '0;
    endcase
  end

  assign timer_irq_o = irq_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the demo fabric testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary -f filelist.f --top-module tb_demo_soc -o sim_demo_soc
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_demo_soc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
  echo "No result line found in sim.log"
  exit 1
fi
exit 0

// ==== test/tb_demo_soc_tasks.svh ====
// Bus access tasks, checks, reference models and test sequences for tb_demo_soc.
// Included inside the testbench module body.
`ifndef TB_DEMO_SOC_TASKS_SVH
`define TB_DEMO_SOC_TASKS_SVH

function automatic bit [31:0] xorshift();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

function automatic bus_word_t ref_merge_be(bus_word_t old_w, bus_word_t new_w, bus_be_t be);
  bus_word_t res;
  for (int i = 0; i < 4; i++) begin
    res[8*i +: 8] = be[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
  end
  return res;
endfunction

function automatic soc_dev_e ref_decode(logic [31:0] addr);
  if (addr[31:16] == 16'h0010) return DevRam;   // 64 KiB at 0x00100000
  if (addr[31:12] == 20'h80000) return DevGpio;
  if (addr[31:12] == 20'h80002) return DevTimer;
  return DevNone;
endfunction

function automatic bus_word_t ram_fill(bit [31:0] idx);
  return (idx * 32'h9E37_79B9) ^ 32'h5A5A_A5A5;  // Unwritten words
endfunction

task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
  if (exp !== act) begin
    $display("error: %s expected %h actual %h", name, exp, act);
    err_count++;
  end
endtask

task automatic wait_accept();
  do @(negedge clk_sys); while (!bus_gnt);
endtask

task automatic wait_rsp(output bus_rsp_t rsp);
  do @(negedge clk_sys); while (!bus_rsp.rvalid);
  rsp = bus_rsp;
endtask

task automatic bus_access(input logic we, input logic [31:0] addr, input bus_be_t be,
                          input bus_word_t wdata, output bus_rsp_t rsp);
  @(posedge clk_sys);
  bus_req.req      <= 1'b1;
  bus_req.we       <= we;
  bus_req.be       <= be;
  bus_req.addr.raw <= addr;
  bus_req.wdata    <= wdata;
  wait_accept();
  @(posedge clk_sys);
  bus_req.req <= 1'b0;  // Dropped on the acceptance edge
  wait_rsp(rsp);
endtask

task automatic bus_write(input logic [31:0] addr, input bus_be_t be, input bus_word_t wdata);
  bus_rsp_t rsp;
  bus_access(1'b1, addr, be, wdata, rsp);
  check("write_err", 64'(ref_decode(addr) == DevNone), 64'(rsp.err));
  check("write_rdata", 64'd0, 64'(rsp.rdata));
endtask

task automatic bus_read(input logic [31:0] addr, output bus_word_t rdata);
  bus_rsp_t rsp;
  bus_access(1'b0, addr, 4'hF, '0, rsp);
  check("read_err", 64'(ref_decode(addr) == DevNone), 64'(rsp.err));
  rdata = rsp.rdata;
endtask

task automatic run_ram_test();
  bit [31:0] addrs[$];
  bus_word_t exp_ram[bit [31:0]];
  bit [31:0] a;
  bus_be_t   be;
  bus_word_t d;
  bus_word_t rd;
  for (int i = 0; i < RamOps; i++) begin
    a  = RamStart | (xorshift() & 32'h0000_FFFC);
    be = 4'(xorshift());
    d  = xorshift();
    if (be == 4'h0) be = 4'hF;
    rd = exp_ram.exists(a >> 2) ? exp_ram[a >> 2] : ram_fill(a >> 2);
    exp_ram[a >> 2] = ref_merge_be(rd, d, be);
    addrs.push_back(a);
    bus_write(a, be, d);
  end
  addrs.push_back(RamStart | 32'h0000_FFF0);  // Likely never written
  foreach (addrs[i]) begin
    a  = addrs[i];
    bus_read(a, rd);
    check("ram_read", 64'(exp_ram.exists(a >> 2) ? exp_ram[a >> 2] : ram_fill(a >> 2)),
          64'(rd));
  end
endtask

task automatic run_gpio_test();
  logic [31:0] gpio_base;
  bus_word_t   exp_out;
  bus_word_t   d;
  bus_word_t   rd;
  bus_be_t     be;
  logic [GpiWidth-1:0] in_val;
  gpio_base = {GpioRegion, 12'h000};
  exp_out   = '0;
  for (int i = 0; i < GpioOps; i++) begin
    be      = 4'(xorshift());
    d       = xorshift();
    exp_out = ref_merge_be(exp_out, d, be) & ((32'd1 << GpoWidth) - 1);
    bus_write(gpio_base | 32'(GpioOutOffset), be, d);
    check("gpio_out_pins", 64'(exp_out), 64'(gp_o));
    bus_read(gpio_base | 32'(GpioOutOffset), rd);
    check("gpio_out_read", 64'(exp_out), 64'(rd));
  end
  in_val = GpiWidth'(xorshift());
  @(posedge clk_sys);
  gp_i <= in_val;
  repeat (3) @(posedge clk_sys);
  bus_read(gpio_base | 32'(GpioInOffset), rd);
  check("gpio_in_read", 64'(in_val), 64'(rd));
endtask

task automatic run_timer_test();
  logic [31:0] tbase;
  bus_word_t   lo;
  bus_word_t   hi;
  logic [63:0] target;
  int          waited;
  tbase = {TimerRegion, 12'h000};
  bus_read(tbase | 32'(MtimeLoOffset), lo);
  bus_read(tbase | 32'(MtimeHiOffset), hi);
  target = {hi, lo} + 64'd20;
  bus_write(tbase | 32'(MtimecmpHiOffset), 4'hF, target[63:32]);
  bus_write(tbase | 32'(MtimecmpLoOffset), 4'hF, target[31:0]);
  check("timer_irq_early", 64'd0, 64'(timer_irq));
  waited = 0;
  while (!timer_irq && waited < 40) begin
    @(negedge clk_sys);
    waited++;
  end
  check("timer_irq_rise", 64'd1, 64'(timer_irq));
  bus_write(tbase | 32'(MtimecmpHiOffset), 4'hF, 32'hFFFF_FFFF);
  repeat (2) @(negedge clk_sys);
  check("timer_irq_clear", 64'd0, 64'(timer_irq));
  bus_read(tbase | 32'(MtimeLoOffset), lo);
  bus_read(tbase | 32'(MtimeLoOffset), hi);
  check("mtime_increase", 64'd1, 64'(hi > lo));
endtask

task automatic run_error_test();
  bus_rsp_t  rsp;
  bus_word_t exp_rd;
  int        held;
  bus_access(1'b0, 32'h9000_0010, 4'hF, '0, rsp);
  check("none_err", 64'd1, 64'(rsp.err));
  check("none_rdata", 64'd0, 64'(rsp.rdata));
  // RAM read held for 4 cycles while a timer read is pending
  force_delay = 4;
  exp_rd      = ram.exists(32'h0010_0100 >> 2) ? ram[32'h0010_0100 >> 2]
                                               : ram_fill(32'h0010_0100 >> 2);
  @(posedge clk_sys);
  bus_req.req      <= 1'b1;
  bus_req.we       <= 1'b0;
  bus_req.be       <= 4'hF;
  bus_req.addr.raw <= 32'h0010_0100;
  wait_accept();
  @(posedge clk_sys);
  bus_req.addr.raw <= {TimerRegion, MtimecmpHiOffset};  // Second request stays up
  held = 0;
  forever begin
    @(negedge clk_sys);
    if (bus_rsp.rvalid) break;
    check("backpressure_gnt", 64'd0, 64'(bus_gnt));
    held++;
  end
  check("backpressure_len", 64'd1, 64'(held >= 4));
  check("backpressure_ram", 64'(exp_rd), 64'(bus_rsp.rdata));
  if (!bus_gnt) wait_accept();
  @(posedge clk_sys);
  bus_req.req <= 1'b0;
  wait_rsp(rsp);
  check("pending_err", 64'd0, 64'(rsp.err));
  check("pending_timer", 64'h0000_0000_FFFF_FFFF, 64'(rsp.rdata));  // Set by the timer test
  force_delay = 0;
endtask

`endif

// ==== test/tb_demo_soc.sv ====
// Testbench for the demo bus fabric. Drives the host port, models the external RAM
// and checks RAM routing, GPIO, timer interrupt, unmapped access and back-pressure.
`timescale 1ns/1ps

module tb_demo_soc;
  import soc_bus_pkg::*;
  import soc_map_pkg::*;

  localparam int GpiWidth   = 8;
  localparam int GpoWidth   = 16;
  localparam int RamOps     = 8;
  localparam int GpioOps    = 6;
  localparam int TestCycles = RamOps * 2 * 8 + GpioOps * 2 * 4 + 200;
  localparam int Margin     = 4;

  logic                clk_sys;
  logic                rst_sys_n;
  bus_req_t            bus_req;
  logic                bus_gnt;
  bus_rsp_t            bus_rsp;
  bus_req_t            mem_req;
  logic                mem_rvalid;
  bus_word_t           mem_rdata;
  logic [GpiWidth-1:0] gp_i;
  logic [GpoWidth-1:0] gp_o;
  logic                timer_irq;

  int          err_count;
  bit   [31:0] rng_state;
  int          force_delay;  // Nonzero fixes the RAM latency
  bus_word_t   ram[bit [31:0]];

  `include "tb_demo_soc_tasks.svh"

  demo_soc_top #(
    .GpiWidth (GpiWidth),
    .GpoWidth (GpoWidth)
  ) uut (
    .clk_sys_i    (clk_sys),
    .rst_sys_ni   (rst_sys_n),
    .bus_req_i    (bus_req),
    .bus_gnt_o    (bus_gnt),
    .bus_rsp_o    (bus_rsp),
    .mem_req_o    (mem_req),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata),
    .gp_i         (gp_i),
    .gp_o         (gp_o),
    .timer_irq_o  (timer_irq)
  );

  initial begin
    clk_sys = 1'b0;
    forever #2 clk_sys = ~clk_sys;
  end

  initial begin
    #(TestCycles * Margin * 4);
    $display("Watchdog expired after %0d ns, the test sequence did not finish",
             TestCycles * Margin * 4);
    $display("Simulation failed");
    $finish;
  end

  // External RAM model, variable latency
  initial begin
    bus_word_t rd;
    bit [31:0] idx;
    int        delay;
    wait (rst_sys_n);
    forever begin
      @(negedge clk_sys);
      if (mem_req.req) begin
        check("ram_req_addr", 64'(bus_req.addr.raw), 64'(mem_req.addr.raw));
        check("ram_req_ctrl", 64'({bus_req.we, bus_req.be}), 64'({mem_req.we, mem_req.be}));
        check("ram_req_wdata", 64'(bus_req.wdata), 64'(mem_req.wdata));
        idx = mem_req.addr.raw >> 2;
        rd  = ram.exists(idx) ? ram[idx] : ram_fill(idx);
        if (mem_req.we) begin
          ram[idx] = ref_merge_be(rd, mem_req.wdata, mem_req.be);
          rd       = '0;
        end
        delay = (force_delay != 0) ? force_delay : int'(xorshift() % 4) + 1;
        repeat (delay) @(posedge clk_sys);
        mem_rvalid <= 1'b1;
        mem_rdata  <= rd;
        @(posedge clk_sys);
        mem_rvalid <= 1'b0;
      end
    end
  end

  initial begin
    err_count   = 0;
    rng_state   = 32'd90;
    force_delay = 0;
    rst_sys_n   = 1'b0;
    bus_req     = '0;
    mem_rvalid  = 1'b0;
    mem_rdata   = '0;
    gp_i        = '0;
    repeat (5) @(posedge clk_sys);
    rst_sys_n <= 1'b1;
    run_ram_test();
    run_gpio_test();
    run_timer_test();
    run_error_test();
    $display("Checks done with %0d errors", err_count);
    if (err_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
